//--- bench/tb_clock_gen.sv
// testbench clock and reset
// 10 ns clock, reset held high for the first 8 rising edges

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 5,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk   = 1'b0;
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

	always #HALF_PERIOD clk = ~clk;

endmodule

//--- bench/tb_mdr.sv
// testbench for top_mdr
// loads operands, runs multiply, divide and square root, checks values and latency

`timescale 1ns/1ps

module tb_mdr;

	localparam int SEED       = 32'h9a9;
	localparam int TIMEOUT    = 40;  // cycles allowed for done
	localparam int RST_WAIT   = 20;
	localparam int RUN_MAX    = 512;
	localparam int N_RAND_MUL = 200;
	localparam int N_RAND_DIV = 100;
	localparam int N_RAND_SQ  = 60;

	logic                 clk;
	logic                 reset;
	logic                 load;
	logic                 start;
	mdr_ctrl_pkg::op_t    op;
	mdr_types_pkg::word_t data;
	mdr_types_pkg::word_t result;
	mdr_types_pkg::word_t remainder;
	logic                 done;

	// run records, written by stimulus at wr and read by the compare process at rd
	string                run_name  [RUN_MAX];
	mdr_ctrl_pkg::op_t    run_op    [RUN_MAX];
	mdr_types_pkg::word_t run_x     [RUN_MAX];
	mdr_types_pkg::word_t run_y     [RUN_MAX];
	int                   run_start [RUN_MAX];
	int                   wr = 0;
	int                   rd = 0;

	int                   cyc = 0;  // rising edges so far
	int                   errors = 0;
	int                   timeouts = 0;
	logic                 done_prev;
	bit                   reset_checked = 1'b0;
	mdr_types_pkg::word_t cur_x;
	mdr_types_pkg::word_t cur_y;
	mdr_types_pkg::word_t exp_res;
	mdr_types_pkg::word_t exp_rem;

	tb_clock_gen u_clk (.clk(clk), .reset(reset));

	top_mdr uut (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.op        (op),
		.start     (start),
		.data      (data),
		.result    (result),
		.remainder (remainder),
		.done      (done)
	);

	//========================================
	// reference model
	//========================================
	function automatic void mdr_model(input mdr_ctrl_pkg::op_t o,
			input mdr_types_pkg::word_t x, input mdr_types_pkg::word_t y,
			output mdr_types_pkg::word_t res, output mdr_types_pkg::word_t rem);
		logic [31:0] prod;
		int          r;
		prod = {16'b0, x} * {16'b0, y};
		r = 0;
		if (o == mdr_ctrl_pkg::OP_DIV) begin
			res = (y == '0) ? '1 : x / y;
			rem = (y == '0) ? x : x % y;
		end else if (o == mdr_ctrl_pkg::OP_SQRT) begin
			while ((r + 1) * (r + 1) <= int'(x))
				r++;
			res = mdr_types_pkg::word_t'(r);
			rem = x - mdr_types_pkg::word_t'(r * r);
		end else begin
			res = prod[15:0];  // low half
			rem = prod[31:16];
		end
	endfunction

	// edges from the start edge to done, one per step plus the init edge
	function automatic mdr_types_pkg::word_t latency_of(input mdr_ctrl_pkg::op_t o);
		if (o == mdr_ctrl_pkg::OP_SQRT)
			return mdr_types_pkg::word_t'(mdr_types_pkg::WIDTH / 2 + 1);
		return mdr_types_pkg::word_t'(mdr_types_pkg::WIDTH + 1);
	endfunction

	//========================================
	// compare tasks
	//========================================
	task automatic check_result(input string name, input mdr_types_pkg::word_t exp,
			input mdr_types_pkg::word_t act);
		if (act !== exp) begin
			$display("Error %s: result expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_remainder(input string name, input mdr_types_pkg::word_t exp,
			input mdr_types_pkg::word_t act);
		if (act !== exp) begin
			$display("Error %s: remainder expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_latency(input string name, input mdr_types_pkg::word_t exp,
			input mdr_types_pkg::word_t act);
		if (act !== exp) begin
			$display("Error %s: latency expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error %s: done expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	always @(posedge clk)
		cyc <= cyc + 1;

	// compare process, samples on the falling edge where outputs are settled
	always @(negedge clk) begin
		if (reset) begin
			done_prev = 1'b0;
		end else begin
			if (!reset_checked) begin
				check_flag("reset", 1'b0, done);
				check_result("reset", '0, result);
				check_remainder("reset", '0, remainder);
				reset_checked = 1'b1;
			end
			if (done && !done_prev) begin
				if (rd >= wr) begin
					$display("done rose while no run was pending");
					errors++;
				end else begin
					mdr_model(run_op[rd], run_x[rd], run_y[rd], exp_res, exp_rem);
					check_result(run_name[rd], exp_res, result);
					check_remainder(run_name[rd], exp_rem, remainder);
					check_latency(run_name[rd], latency_of(run_op[rd]),
						mdr_types_pkg::word_t'(cyc - run_start[rd]));
					rd++;
				end
			end
			done_prev = done;
		end
	end

	//========================================
	// stimulus
	//========================================
	task automatic load_word(input mdr_types_pkg::word_t value);
		@(posedge clk);
		load <= 1'b1;
		data <= value;
		@(posedge clk);
		load <= 1'b0;
		@(posedge clk);  // sequencer moves on after the loaded flag
	endtask

	task automatic load_pair(input mdr_types_pkg::word_t a, input mdr_types_pkg::word_t b);
		load_word(a);
		load_word(b);
		cur_x = a;
		cur_y = b;
	endtask

	// pulse start, then wait for done; a second start goes in at glitch_at if positive
	task automatic issue_run(input string name, input mdr_ctrl_pkg::op_t o,
			input int glitch_at);
		int n;
		n = 0;
		run_name[wr] = name;
		run_op[wr]   = o;
		run_x[wr]    = cur_x;
		run_y[wr]    = cur_y;
		@(posedge clk);
		start <= 1'b1;
		op    <= o;
		@(posedge clk);  // start edge
		start <= 1'b0;
		@(negedge clk);
		run_start[wr] = cyc;
		wr++;
		while (!done && n < TIMEOUT) begin
			@(posedge clk);
			n++;
			if (n == glitch_at) begin
				start <= 1'b1;
				op    <= (o == mdr_ctrl_pkg::OP_MUL) ? mdr_ctrl_pkg::OP_DIV
				                                     : mdr_ctrl_pkg::OP_MUL;
			end else begin
				start <= 1'b0;
			end
			@(negedge clk);
		end
		if (!done) begin
			$display("timeout: done never rose for %s", name);
			timeouts++;
		end
	endtask

	initial begin
		int                   n;
		int                   i;
		int                   j;
		mdr_types_pkg::word_t a;
		mdr_types_pkg::word_t b;
		mdr_types_pkg::word_t corners [3];
		int                   roots [9];
		load  <= 1'b0;
		start <= 1'b0;
		op    <= mdr_ctrl_pkg::OP_MUL;
		data  <= '0;
		corners = '{16'h0000, 16'h0001, 16'hffff};
		roots   = '{0, 1, 2, 3, 15, 16, 100, 181, 255};
		void'($urandom(SEED));
		n = 0;
		@(posedge clk);
		while (reset && n < RST_WAIT) begin
			@(posedge clk);
			n++;
		end
		if (reset) begin
			$display("timeout: reset never released");
			timeouts++;
		end
		@(negedge clk);

		// multiply
		for (i = 0; i < 3; i++)
			for (j = 0; j < 3; j++) begin
				load_pair(corners[i], corners[j]);
				issue_run($sformatf("mul corner %0d/%0d", i, j), mdr_ctrl_pkg::OP_MUL, 0);
			end
		for (i = 0; i < N_RAND_MUL; i++) begin
			load_pair(mdr_types_pkg::word_t'($urandom), mdr_types_pkg::word_t'($urandom));
			issue_run($sformatf("mul rand %0d", i), mdr_ctrl_pkg::OP_MUL, 0);
		end

		// divide
		load_pair(16'd5, 16'd9);
		issue_run("div y above x", mdr_ctrl_pkg::OP_DIV, 0);
		load_pair(mdr_types_pkg::word_t'($urandom), 16'd1);
		issue_run("div by one", mdr_ctrl_pkg::OP_DIV, 0);
		load_pair(mdr_types_pkg::word_t'($urandom), 16'd0);
		issue_run("div by zero", mdr_ctrl_pkg::OP_DIV, 0);
		load_pair(16'hffff, 16'hffff);
		issue_run("div max", mdr_ctrl_pkg::OP_DIV, 0);
		for (i = 0; i < N_RAND_DIV; i++) begin
			a = mdr_types_pkg::word_t'($urandom);
			b = mdr_types_pkg::word_t'($urandom) >> ($urandom % 16); // spread divisor size
			load_pair(a, b);
			issue_run($sformatf("div rand %0d", i), mdr_ctrl_pkg::OP_DIV, 0);
		end

		// square root, Y loaded but unused
		for (i = 0; i < 9; i++) begin
			load_pair(mdr_types_pkg::word_t'(roots[i] * roots[i]), 16'h1234);
			issue_run($sformatf("sqrt square %0d", roots[i]), mdr_ctrl_pkg::OP_SQRT, 0);
		end
		load_pair(16'hffff, 16'h0);
		issue_run("sqrt max", mdr_ctrl_pkg::OP_SQRT, 0);
		for (i = 0; i < N_RAND_SQ; i++) begin
			load_pair(mdr_types_pkg::word_t'($urandom), mdr_types_pkg::word_t'($urandom));
			issue_run($sformatf("sqrt rand %0d", i), mdr_ctrl_pkg::OP_SQRT, 0);
		end

		// restart from done with the same operands
		load_pair(16'd1000, 16'd37);
		issue_run("redo mul", mdr_ctrl_pkg::OP_MUL, 0);
		issue_run("redo div", mdr_ctrl_pkg::OP_DIV, 0);
		issue_run("redo sqrt", mdr_ctrl_pkg::OP_SQRT, 0);

		// start pulses during a run are ignored
		load_pair(16'd12345, 16'd77);
		issue_run("mid-run start div", mdr_ctrl_pkg::OP_DIV, 5);
		issue_run("mid-run start sqrt", mdr_ctrl_pkg::OP_SQRT, 3);
		issue_run("mid-run start mul", mdr_ctrl_pkg::OP_MUL, 10);

		repeat (2) @(posedge clk);
		$display("runs %0d, unchecked %0d, errors %0d, timeouts %0d",
			wr, wr - rd, errors, timeouts);
		if (errors == 0 && timeouts == 0 && rd == wr)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- build.f
common/mdr_types_pkg.sv
common/mdr_ctrl_pkg.sv
common/mdr_ctrl_if.sv
mdr/mdr_operand_regs.sv
mdr/mdr_sequencer.sv
mdr/mdr_step_logic.sv
mdr/mdr_datapath.sv
hdl/top_mdr.sv
bench/tb_clock_gen.sv
bench/tb_mdr.sv

//--- common/mdr_ctrl_if.sv
// mdr control interface
// carries init, step, last and op from the sequencer to the datapath

`timescale 1ns/1ps

interface mdr_ctrl_if;

	logic              init; // one cycle, loads the AQ register
	logic              step; // one AQ update per cycle while high
	logic              last; // final step of the run
	mdr_ctrl_pkg::op_t op;   // op latched at start

	// sequencer side
	modport seq (
		output init,
		output step,
		output last,
		output op
	);

	// datapath side
	modport dp (
		input init,
		input step,
		input last,
		input op
	);

endinterface

//--- common/mdr_ctrl_pkg.sv
// mdr control package
// op codes, sequencer states and the number of steps per operation

package mdr_ctrl_pkg;

	//========================================
	// op codes
	//========================================
	typedef logic [1:0] op_t;

	localparam op_t OP_MUL  = 2'd0;
	localparam op_t OP_DIV  = 2'd1;
	localparam op_t OP_SQRT = 2'd2; // code 3 falls back to multiply

	//========================================
	// sequencer states
	//========================================
	typedef enum logic [2:0] {
		S_IDLE,   // waiting for X
		S_HAVE_X, // waiting for Y
		S_READY,  // both operands held, waiting for start
		S_RUN,    // iterating
		S_DONE    // result valid
	} seq_state_t;

	// iterations per run
	localparam mdr_types_pkg::cnt_t STEPS_MUL_DIV =
		mdr_types_pkg::cnt_t'(mdr_types_pkg::WIDTH);
	localparam mdr_types_pkg::cnt_t STEPS_SQRT =
		mdr_types_pkg::cnt_t'(mdr_types_pkg::WIDTH/2);

endpackage

//--- common/mdr_types_pkg.sv
// mdr types package
// operand widths and vector types for the multiply/divide/sqrt unit

package mdr_types_pkg;

	//========================================
	// widths
	//========================================
	localparam int WIDTH     = 16;          // operand width N
	localparam int AQ_WIDTH  = 2*WIDTH + 1; // {E, A, Q}
	localparam int CNT_WIDTH = 5;           // holds a count of WIDTH steps

	// bit positions inside the AQ word
	localparam int Q_LSB = 0;
	localparam int A_LSB = WIDTH;
	localparam int E_BIT = 2*WIDTH;

	// square root keeps its root in the upper byte of A
	localparam int ROOT_WIDTH = WIDTH/2;

	//========================================
	// vector types
	//========================================
	typedef logic [WIDTH-1:0]     word_t;  // operand, result, remainder
	typedef logic [AQ_WIDTH-1:0]  aq_t;    // working register {E, A, Q}
	typedef logic [CNT_WIDTH-1:0] cnt_t;   // iteration count

	typedef logic [ROOT_WIDTH-1:0] root_t; // partial square root

endpackage

//--- hdl/top_mdr.sv
// top_mdr
// iterative unsigned multiply, divide and square root unit

`timescale 1ns/1ps

module top_mdr (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 load,
	input  mdr_ctrl_pkg::op_t    op,
	input  logic                 start,
	input  mdr_types_pkg::word_t data,
	output mdr_types_pkg::word_t result,
	output mdr_types_pkg::word_t remainder,
	output logic                 done
);

	mdr_types_pkg::word_t x;
	mdr_types_pkg::word_t y;
	logic                 sel;
	logic                 loaded_x;
	logic                 loaded_y;

	mdr_ctrl_if ctrl ();

	mdr_operand_regs u_operands (
		.clk      (clk),
		.reset    (reset),
		.load     (load),
		.sel      (sel),
		.data     (data),
		.x        (x),
		.y        (y),
		.loaded_x (loaded_x),
		.loaded_y (loaded_y)
	);

	mdr_sequencer u_seq (
		.clk      (clk),
		.reset    (reset),
		.load     (load),
		.start    (start),
		.op       (op),
		.loaded_x (loaded_x),
		.loaded_y (loaded_y),
		.sel      (sel),
		.done     (done),
		.ctrl     (ctrl.seq)
	);

	mdr_datapath u_dp (
		.clk       (clk),
		.reset     (reset),
		.x         (x),
		.y         (y),
		.ctrl      (ctrl.dp),
		.result    (result),
		.remainder (remainder)
	);

endmodule

//--- mdr/mdr_datapath.sv
// mdr datapath
// AQ working register, initialized from X and advanced by the step logic

`timescale 1ns/1ps

module mdr_datapath (
	input  logic                 clk,
	input  logic                 reset,
	input  mdr_types_pkg::word_t x,
	input  mdr_types_pkg::word_t y,
	mdr_ctrl_if.dp               ctrl,
	output mdr_types_pkg::word_t result,
	output mdr_types_pkg::word_t remainder
);

	localparam int W = mdr_types_pkg::WIDTH;
	localparam int R = mdr_types_pkg::ROOT_WIDTH;

	mdr_types_pkg::aq_t aq;
	mdr_types_pkg::aq_t next_aq;
	mdr_ctrl_pkg::op_t  aq_op;   // op of the run held in aq

	mdr_step_logic u_step (
		.aq      (aq),
		.y       (y),
		.op      (ctrl.op),
		.next_aq (next_aq)
	);

	// E and A cleared (this also clears the root field), Q takes X
	always_ff @(posedge clk) begin
		if (reset) begin
			aq    <= '0;
			aq_op <= mdr_ctrl_pkg::OP_MUL;
		end else if (ctrl.init) begin
			aq    <= {1'b0, {W{1'b0}}, x};
			aq_op <= ctrl.op;
		end else if (ctrl.step)
			aq <= next_aq;
	end

	//========================================
	// outputs
	//========================================
	always_comb begin
		if (aq_op == mdr_ctrl_pkg::OP_SQRT) begin
			result    = {{(W-R){1'b0}}, aq[mdr_types_pkg::A_LSB+W-1 -: R]};
			remainder = {{(W-R-1){1'b0}}, aq[mdr_types_pkg::E_BIT],
			             aq[mdr_types_pkg::A_LSB +: R]};
		end else begin
			result    = aq[mdr_types_pkg::Q_LSB +: W];
			remainder = aq[mdr_types_pkg::A_LSB +: W];
		end
	end

	// restoring divide must leave a remainder below the divisor
	a_div_rem: assert property (
		@(posedge clk) disable iff (reset)
		(ctrl.step && ctrl.last && ctrl.op == mdr_ctrl_pkg::OP_DIV && y != '0)
		|=> (remainder < y)
	) else $error("divide remainder not below divisor");

endmodule

//--- mdr/mdr_operand_regs.sv
// mdr operand registers
// steers each load pulse into X or Y and flags the capture one cycle later

`timescale 1ns/1ps

module mdr_operand_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 load,
	input  logic                 sel,      // 0 -> X, 1 -> Y
	input  mdr_types_pkg::word_t data,
	output mdr_types_pkg::word_t x,
	output mdr_types_pkg::word_t y,
	output logic                 loaded_x,
	output logic                 loaded_y
);

	logic load_x; // demux outputs
	logic load_y;

	assign load_x = load & ~sel;
	assign load_y = load & sel;

	// operand payload
	always_ff @(posedge clk) begin
		if (load_x)
			x <= data;
		if (load_y)
			y <= data;
	end

	// capture flags
	always_ff @(posedge clk) begin
		if (reset) begin
			loaded_x <= 1'b0;
			loaded_y <= 1'b0;
		end else begin
			loaded_x <= load_x;
			loaded_y <= load_y;
		end
	end

endmodule

//--- mdr/mdr_sequencer.sv
// mdr sequencer
// FSM for operand entry and the run, op latch and step counter

`timescale 1ns/1ps

module mdr_sequencer (
	input  logic              clk,
	input  logic              reset,
	input  logic              load,
	input  logic              start,
	input  mdr_ctrl_pkg::op_t op,
	input  logic              loaded_x,
	input  logic              loaded_y,
	output logic              sel,
	output logic              done,
	mdr_ctrl_if.seq           ctrl
);

	mdr_ctrl_pkg::seq_state_t state;
	mdr_ctrl_pkg::op_t        op_q;   // op held for the whole run
	mdr_types_pkg::cnt_t      cnt;    // steps applied so far
	mdr_types_pkg::cnt_t      steps;  // steps needed for op_q
	logic                     init_q;
	logic                     step;
	logic                     last;

	assign steps = (op_q == mdr_ctrl_pkg::OP_SQRT) ? mdr_ctrl_pkg::STEPS_SQRT
	                                               : mdr_ctrl_pkg::STEPS_MUL_DIV;

	// no step in the init cycle
	assign step = (state == mdr_ctrl_pkg::S_RUN) && !init_q;
	assign last = step && (cnt == steps - 1'b1);
	assign sel  = (state == mdr_ctrl_pkg::S_HAVE_X);

	assign ctrl.init = init_q;
	assign ctrl.step = step;
	assign ctrl.last = last;
	assign ctrl.op   = op_q;

	//========================================
	// state machine
	//========================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= mdr_ctrl_pkg::S_IDLE;
			op_q   <= mdr_ctrl_pkg::OP_MUL;
			cnt    <= '0;
			init_q <= 1'b0;
			done   <= 1'b0;
		end else begin
			init_q <= 1'b0;
			case (state)
				mdr_ctrl_pkg::S_IDLE: begin
					if (loaded_x)
						state <= mdr_ctrl_pkg::S_HAVE_X;
				end
				mdr_ctrl_pkg::S_HAVE_X: begin
					if (loaded_y)
						state <= mdr_ctrl_pkg::S_READY;
				end
				mdr_ctrl_pkg::S_READY, mdr_ctrl_pkg::S_DONE: begin
					if (start) begin
						state  <= mdr_ctrl_pkg::S_RUN;
						op_q   <= op;
						cnt    <= '0;
						init_q <= 1'b1; // AQ loads on the next edge
						done   <= 1'b0;
					end else if (state == mdr_ctrl_pkg::S_DONE) begin
						if (load)
							done <= 1'b0; // new operand entry begins
						if (loaded_x)
							state <= mdr_ctrl_pkg::S_HAVE_X;
					end
				end
				mdr_ctrl_pkg::S_RUN: begin
					if (step)
						cnt <= cnt + 1'b1;
					if (last) begin
						state <= mdr_ctrl_pkg::S_DONE;
						done  <= 1'b1;
					end
				end
				default: state <= mdr_ctrl_pkg::S_IDLE;
			endcase
		end
	end

	//========================================
	// checks
	//========================================
	// steps of a run come back to back up to the last one
	a_step_run: assert property (
		@(posedge clk) disable iff (reset)
		(ctrl.step && !ctrl.last) |=> ctrl.step
	) else $error("step dropped before the last step");

	a_cnt_range: assert property (
		@(posedge clk) disable iff (reset)
		cnt <= mdr_ctrl_pkg::STEPS_MUL_DIV
	) else $error("step counter overran");

endmodule

//--- mdr/mdr_step_logic.sv
// mdr step logic
// one combinational iteration of multiply, restoring divide or square root

`timescale 1ns/1ps

module mdr_step_logic (
	input  mdr_types_pkg::aq_t   aq,
	input  mdr_types_pkg::word_t y,
	input  mdr_ctrl_pkg::op_t    op,
	output mdr_types_pkg::aq_t   next_aq
);

	localparam int W = mdr_types_pkg::WIDTH;
	localparam int R = mdr_types_pkg::ROOT_WIDTH;

	mdr_types_pkg::word_t a;
	mdr_types_pkg::word_t q;

	// multiply
	logic [W:0]   mul_sum;   // {carry, A + Y}
	logic [W:0]   mul_ea;    // {E, A} before the shift

	// divide
	logic [W:0]   div_sh;    // {A, Q msb}
	logic [W+1:0] div_diff;  // sign in the top bit

	// square root, root in A[15:8], remainder in {E, A[7:0]}
	mdr_types_pkg::root_t root;
	logic [R:0]   sq_rem;
	logic [R+2:0] sq_trial;  // remainder with the next bit pair
	logic [R+3:0] sq_diff;
	logic         sq_bit;
	logic [R:0]   sq_rem_n;

	assign a = aq[mdr_types_pkg::A_LSB +: W];
	assign q = aq[mdr_types_pkg::Q_LSB +: W];

	//========================================
	// per-op datapaths
	//========================================
	assign mul_sum = {1'b0, a} + {1'b0, y};
	assign mul_ea  = q[0] ? mul_sum : {aq[mdr_types_pkg::E_BIT], a};

	assign div_sh   = {a, q[W-1]};
	assign div_diff = {1'b0, div_sh} - {2'b00, y};

	assign root     = a[W-1 -: R];
	assign sq_rem   = {aq[mdr_types_pkg::E_BIT], a[R-1:0]};
	assign sq_trial = {sq_rem, q[W-1 -: 2]};
	assign sq_diff  = {1'b0, sq_trial} - {2'b00, root, 2'b01}; // 4r + 1
	assign sq_bit   = ~sq_diff[R+3];
	assign sq_rem_n = sq_bit ? sq_diff[R:0] : sq_trial[R:0]; // fits, rem <= 2*root

	//========================================
	// result select
	//========================================
	always_comb begin
		case (op)
			mdr_ctrl_pkg::OP_DIV: begin
				if (!div_diff[W+1]) // trial not negative
					next_aq = {1'b0, div_diff[W-1:0], q[W-2:0], 1'b1};
				else
					next_aq = {1'b1, div_sh[W-1:0], q[W-2:0], 1'b0};
			end
			mdr_ctrl_pkg::OP_SQRT: begin
				next_aq = {sq_rem_n[R], root[R-2:0], sq_bit, sq_rem_n[R-1:0],
				           q[W-3:0], 2'b00};
			end
			default: begin
				next_aq = {1'b0, mul_ea, q[W-1:1]}; // shift right by one
			end
		endcase
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the top_mdr testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
	-f build.f --top-module tb_mdr -Mdir obj_dir -o tb_mdr

./obj_dir/tb_mdr | tee sim.log

if grep -q "=== PASS ===" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
